// ==== dv/uProcChecker.sv ====
/*
 * SRAM strobe checker.
 * Concurrent assertions on the bridge outputs.
 */
`timescale 1ns/10ps

module uProcChecker (
    input logic clk,
    input logic rstN,
    input logic sramEn,
    input logic sramWr,
    input logic sramDataOe
);

    // A write is always an enabled access.
    wrNeedsEn: assert property (@(posedge clk) disable iff (!rstN) sramWr |-> sramEn)
        else $error("sramWr high without sramEn");

    // Single-cycle accesses.
    enSingle: assert property (@(posedge clk) disable iff (!rstN) sramEn |=> !sramEn)
        else $error("sramEn held longer than one cycle");

    // Data driven only while writing.
    oeMatchesWr: assert property (@(posedge clk) disable iff (!rstN) sramDataOe == sramWr)
        else $error("sramDataOe differs from sramWr");

    quietInReset: assert property (@(posedge clk) !rstN |-> !sramEn && !sramWr && !sramDataOe)
        else $error("SRAM strobe active during reset");

endmodule

bind sramBridge uProcChecker strobeCheck (
    .clk        (clk),
    .rstN       (rstN),
    .sramEn     (sramEn),
    .sramWr     (sramWr),
    .sramDataOe (sramDataOe)
);

// ==== dv/uProcTb.sv ====
/*
 * uProc testbench.
 * Table of JTAG scans against the debug path, with an SRAM model.
 */
`timescale 1ns/10ps
`include "uProc_defs.svh"

module uProcTb;
    import uProcPkg::*;

    // Instruction, scan-in, expected scan-out, check enable and core status.
    typedef struct packed {
        logic [3:0]  ir;
        logic [31:0] din;
        logic [31:0] dout;
        logic        chk;
        logic [1:0]  status;
    } scanEntry_s;

    localparam int NW    = 4;
    localparam int NE    = 13;
    localparam int LIMIT = (NE + 3) * 60 * 8 + 500;

    logic        clk, rstN, tck, tdi, tms, tdo, isBooted, isPaused;
    logic [15:0] sramAddr, sramDataOut, sramDataIn;
    logic        sramDataOe, sramWr, sramEn, enScanRelay, enSPIRelay, enPaused;
    logic [15:0] mem [0:65535];
    logic [15:0] wAddr [NW];
    logic [15:0] wData [NW];
    scanEntry_s  scans [NE];
    int          seed, errors, checks, cycles, wrCount;

    uProc dut (.*);

    always #2 clk = ~clk;

    // Fill word built from every address bit.
    function automatic logic [15:0] fillWord(input logic [15:0] a);
        return {a[7:0], a[15:8]} ^ 16'hC35A;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // SRAM model
    ////////////////////////////////////////////////////////////////////////////

    assign sramDataIn = mem[sramAddr];

    // Strobes sampled as they were before the edge.
    initial begin : sramModel
        logic [16:0] a;
        wrCount = 0;
        for (a = 0; a < 17'h10000; a++) begin
            mem[a[15:0]] = fillWord(a[15:0]);
        end
        forever begin
            @(posedge clk);
            if (sramEn && sramWr) begin
                // Write data must be driven onto the bus.
                compareWord("sramDataOe", 32'h1, {31'b0, sramDataOe});
                mem[sramAddr] = sramDataOut;
                wrCount++;
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: no result after %0d clk cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic compareWord(input string name, input logic [31:0] expV,
                               input logic [31:0] gotV);
        checks++;
        assert (gotV == expV) else begin
            errors++;
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expV, gotV);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // JTAG driver
    ////////////////////////////////////////////////////////////////////////////

    // One TCK period of 4 clk low then 4 clk high.
    // TDO is taken just before the rise.
    task automatic tckCycle(input logic tmsV, input logic tdiV, output logic tdoV);
        tck = 1'b0;
        tms = tmsV;
        tdi = tdiV;
        repeat (4) @(posedge clk);
        #1;
        tdoV = tdo;
        tck  = 1'b1;
        repeat (4) @(posedge clk);
        #1;
    endtask

    // Idle to Idle with the LSB first.
    task automatic scanIr(input logic [3:0] code, output logic [3:0] out);
        logic b;
        tckCycle(1'b1, 1'b0, b);
        tckCycle(1'b1, 1'b0, b);
        tckCycle(1'b0, 1'b0, b);
        tckCycle(1'b0, 1'b0, b);
        for (int i = 0; i < 4; i++) begin
            tckCycle(i == 3, code[i], b);
            out[i] = b;
        end
        tckCycle(1'b1, 1'b0, b);
        tckCycle(1'b0, 1'b0, b);
    endtask

    // Extra idle period lets an SRAM strobe finish.
    task automatic scanDr(input logic [31:0] din, output logic [31:0] dout);
        logic b;
        tckCycle(1'b1, 1'b0, b);
        tckCycle(1'b0, 1'b0, b);
        tckCycle(1'b0, 1'b0, b);
        for (int i = 0; i < 32; i++) begin
            tckCycle(i == 31, din[i], b);
            dout[i] = b;
        end
        tckCycle(1'b1, 1'b0, b);
        tckCycle(1'b0, 1'b0, b);
        tckCycle(1'b0, 1'b0, b);
    endtask

    initial begin
        logic [31:0] got, r;
        logic [3:0]  irOut;
        logic [15:0] fillAddr;
        logic        b;
        int          n;
        clk = 0;
        rstN = 1;
        tck = 0;
        tdi = 0;
        tms = 0;
        isBooted = 1;
        isPaused = 0;
        seed = 82;
        errors = 0;
        checks = 0;
        cycles = 0;
        n = 0;
        // Distinct write addresses with the index in the low bits.
        for (int i = 0; i < NW; i++) begin
            r = $random(seed);
            wAddr[i] = {r[15:2], 2'(i)};
            r = $random(seed);
            wData[i] = r[15:0];
            scans[n] = '{irSramWrite, {wAddr[i], wData[i]}, 32'h0, 1'b1, 2'b10};
            n++;
        end
        // Each read returns the previous read's address and word.
        scans[n] = '{irSramRead, {wAddr[0], 16'h0}, 32'h0, 1'b0, 2'b10};
        n++;
        for (int i = 1; i < NW; i++) begin
            scans[n] = '{irSramRead, {wAddr[i], 16'h0}, {wAddr[i-1], wData[i-1]},
                         1'b1, 2'b10};
            n++;
        end
        fillAddr = wAddr[0] ^ 16'h8000;
        scans[n] = '{irSramRead, {fillAddr, 16'h0}, {wAddr[NW-1], wData[NW-1]},
                     1'b1, 2'b10};
        scans[n+1] = '{irSramRead, {wAddr[1], 16'h0}, {fillAddr, fillWord(fillAddr)},
                       1'b1, 2'b10};
        // Control word ends in isBooted, isPaused, enPaused, enSPIRelay and enScanRelay.
        // Status levels swap so each input is seen high and low.
        scans[n+2] = '{irControl, 32'h5, {27'b0, 5'b10000}, 1'b1, 2'b10};
        scans[n+3] = '{irControl, 32'h2, {27'b0, 5'b01101}, 1'b1, 2'b01};
        r = $random(seed);
        scans[n+4] = '{irBypass, r, {r[30:0], 1'b0}, 1'b1, 2'b10};

        #1 rstN = 0;
        repeat (2) @(posedge clk);
        #1 rstN = 1;
        compareWord("outputs after reset", 32'h0, {25'b0, tdo, sramEn, sramWr, sramDataOe,
                                                   enPaused, enSPIRelay, enScanRelay});
        tckCycle(1'b0, 1'b0, b);
        scanDr(32'h0, got);
        compareWord("IDCODE", `UPROC_IDCODE, got);

        for (int e = 0; e < NE; e++) begin
            {isBooted, isPaused} = scans[e].status;
            scanIr(scans[e].ir, irOut);
            compareWord("IR capture", 32'h1, {28'b0, irOut});
            scanDr(scans[e].din, got);
            if (scans[e].chk) begin
                compareWord("DR scan-out", scans[e].dout, got);
            end
        end

        compareWord("sramWr pulses", NW, wrCount);
        for (int i = 0; i < NW; i++) begin
            compareWord("SRAM word", {16'b0, wData[i]}, {16'b0, mem[wAddr[i]]});
        end
        compareWord("control levels", 32'h2, {29'b0, enPaused, enSPIRelay, enScanRelay});

        // TMS high for five periods forces Test-Logic-Reset.
        repeat (5) tckCycle(1'b1, 1'b0, b);
        tckCycle(1'b0, 1'b0, b);
        compareWord("levels after TAP reset", 32'h0,
                    {29'b0, enPaused, enSPIRelay, enScanRelay});
        scanDr(32'h0, got);
        compareWord("IDCODE after TAP reset", `UPROC_IDCODE, got);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== hw/jtagPort.sv ====
/*
 * JTAG debug port.
 * IR and DR shifting, instruction decode, control levels and TDO.
 * Update-DR scans become SRAM requests for the bridge.
 */
`timescale 1ns/10ps
`include "uProc_defs.svh"

module jtagPort (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      tck,
    input  logic                      tdi,
    input  logic                      tms,
    output logic                      tdo,
    input  logic                      isBooted,
    input  logic                      isPaused,
    input  logic [`UPROC_SRAM_DW-1:0] readData,
    output uProcPkg::sramReq_s        sramReq,
    output logic                      enScanRelay,
    output logic                      enSPIRelay,
    output logic                      enPaused
);
    import uProcPkg::*;

    tapState_e                 tapState;
    logic                      tckRise;
    logic                      tckFall;
    logic [`UPROC_IR_WIDTH-1:0] irShift;
    jtagIr_e                   ir;
    jtagDr_u                   dr;
    logic                      bypassReg;
    logic [`UPROC_SRAM_AW-1:0] lastReadAddr;
    logic                      shiftOut;

    jtagTap tap (
        .clk     (clk),
        .rstN    (rstN),
        .tck     (tck),
        .tms     (tms),
        .state   (tapState),
        .tckRise (tckRise),
        .tckFall (tckFall)
    );

    // Unknown codes act as bypass.
    function automatic jtagIr_e decodeIr(input logic [`UPROC_IR_WIDTH-1:0] code);
        jtagIr_e result;
        if (code inside {irIdcode, irSramWrite, irSramRead, irControl, irBypass}) begin
            result = jtagIr_e'(code);
        end else begin
            result = irBypass;
        end
        return result;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Scan registers
    ////////////////////////////////////////////////////////////////////////////

    // Capture and shift on TCK rise.
    // TDI enters at the top, bit 0 leaves.
    always_ff @(posedge clk) begin
        if (tckRise) begin
            case (tapState)
                tapCaptureIr: irShift <= {{(`UPROC_IR_WIDTH-1){1'b0}}, 1'b1};
                tapShiftIr:   irShift <= {tdi, irShift[`UPROC_IR_WIDTH-1:1]};
                tapCaptureDr: begin
                    bypassReg <= 1'b0;
                    case (ir)
                        irIdcode: dr.raw <= `UPROC_IDCODE;
                        irSramRead: begin
                            dr.mem.addr <= lastReadAddr;
                            dr.mem.data <= readData;
                        end
                        irControl: dr.ctrl <= '{reserved: '0, isBooted: isBooted,
                                                isPaused: isPaused, enPaused: enPaused,
                                                enSPIRelay: enSPIRelay,
                                                enScanRelay: enScanRelay};
                        default: dr.raw <= '0;
                    endcase
                end
                tapShiftDr: begin
                    if (ir == irBypass) begin
                        bypassReg <= tdi;
                    end else begin
                        dr.raw <= {tdi, dr.raw[`UPROC_DR_WIDTH-1:1]};
                    end
                end
                // Address for the next read capture.
                tapUpdateDr: if (ir == irSramRead) lastReadAddr <= dr.mem.addr;
                default: ;
            endcase
        end
    end

    // Bit presented on TDO while shifting.
    always_comb begin
        case (tapState)
            tapShiftIr: shiftOut = irShift[0];
            tapShiftDr: shiftOut = (ir == irBypass) ? bypassReg : dr.raw[0];
            default:    shiftOut = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Instruction, control levels, requests and TDO
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ir          <= irIdcode;
            enScanRelay <= 1'b0;
            enSPIRelay  <= 1'b0;
            enPaused    <= 1'b0;
            sramReq     <= '0;
            tdo         <= 1'b0;
        end else begin
            // Requests last one clk.
            sramReq.wr <= 1'b0;
            sramReq.rd <= 1'b0;
            if (tapState == tapReset) begin
                ir          <= irIdcode;
                enScanRelay <= 1'b0;
                enSPIRelay  <= 1'b0;
                enPaused    <= 1'b0;
            end else if (tckRise && tapState == tapUpdateIr) begin
                ir <= decodeIr(irShift);
            end else if (tckRise && tapState == tapUpdateDr) begin
                case (ir)
                    irSramWrite: sramReq <= '{wr: 1'b1, rd: 1'b0,
                                              addr: dr.mem.addr, data: dr.mem.data};
                    irSramRead:  sramReq <= '{wr: 1'b0, rd: 1'b1,
                                              addr: dr.mem.addr, data: dr.mem.data};
                    irControl: begin
                        enScanRelay <= dr.ctrl.enScanRelay;
                        enSPIRelay  <= dr.ctrl.enSPIRelay;
                        enPaused    <= dr.ctrl.enPaused;
                    end
                    default: ;
                endcase
            end
            // TDO changes on the falling edge.
            if (tckFall) begin
                tdo <= shiftOut;
            end
        end
    end

endmodule

// ==== hw/jtagSync.sv ====
/*
 * JTAG pin synchronizer.
 * Register chain per pin into the clk domain.
 */
`timescale 1ns/10ps
`include "uProc_defs.svh"

module jtagSync (
    input  logic       clk,
    input  logic       rstN,
    input  logic [2:0] async,
    output logic [2:0] sync
);

    // One chain per pin with the oldest stage at the top.
    logic [2:0][`UPROC_SYNC_STAGES-1:0] stage;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stage <= '0;
        end else begin
            for (int i = 0; i < 3; i++) begin
                stage[i] <= {stage[i][`UPROC_SYNC_STAGES-2:0], async[i]};
            end
        end
    end

    // Last stage drives the clk logic.
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            sync[i] = stage[i][`UPROC_SYNC_STAGES-1];
        end
    end

endmodule

// ==== hw/jtagTap.sv ====
/*
 * JTAG TAP controller.
 * Detects TCK edges by oversampling and steps the sixteen-state FSM.
 */
`timescale 1ns/10ps

module jtagTap (
    input  logic                clk,
    input  logic                rstN,
    input  logic                tck,
    input  logic                tms,
    output uProcPkg::tapState_e state,
    output logic                tckRise,
    output logic                tckFall
);
    import uProcPkg::*;

    // Previous TCK sample.
    logic tckQ;

    ////////////////////////////////////////////////////////////////////////////
    // TCK edge pulses
    ////////////////////////////////////////////////////////////////////////////

    // One clk wide, one clk after the edge.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            tckQ    <= 1'b0;
            tckRise <= 1'b0;
            tckFall <= 1'b0;
        end else begin
            tckQ    <= tck;
            tckRise <= tck & ~tckQ;
            tckFall <= ~tck & tckQ;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // TAP state machine
    ////////////////////////////////////////////////////////////////////////////

    // IEEE transition table.
    function automatic tapState_e nextState(input tapState_e cur, input logic tmsIn);
        tapState_e nxt;
        case (cur)
            tapReset:     nxt = tmsIn ? tapReset    : tapIdle;
            tapIdle:      nxt = tmsIn ? tapSelectDr : tapIdle;
            tapSelectDr:  nxt = tmsIn ? tapSelectIr : tapCaptureDr;
            tapCaptureDr: nxt = tmsIn ? tapExit1Dr  : tapShiftDr;
            tapShiftDr:   nxt = tmsIn ? tapExit1Dr  : tapShiftDr;
            tapExit1Dr:   nxt = tmsIn ? tapUpdateDr : tapPauseDr;
            tapPauseDr:   nxt = tmsIn ? tapExit2Dr  : tapPauseDr;
            tapExit2Dr:   nxt = tmsIn ? tapUpdateDr : tapShiftDr;
            tapUpdateDr:  nxt = tmsIn ? tapSelectDr : tapIdle;
            tapSelectIr:  nxt = tmsIn ? tapReset    : tapCaptureIr;
            tapCaptureIr: nxt = tmsIn ? tapExit1Ir  : tapShiftIr;
            tapShiftIr:   nxt = tmsIn ? tapExit1Ir  : tapShiftIr;
            tapExit1Ir:   nxt = tmsIn ? tapUpdateIr : tapPauseIr;
            tapPauseIr:   nxt = tmsIn ? tapExit2Ir  : tapPauseIr;
            tapExit2Ir:   nxt = tmsIn ? tapUpdateIr : tapShiftIr;
            tapUpdateIr:  nxt = tmsIn ? tapSelectDr : tapIdle;
            default:      nxt = tapReset;
        endcase
        return nxt;
    endfunction

    // Advance on TCK rise only.
    // TMS is stable then, TCK levels last several clk.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= tapReset;
        end else if (tckRise) begin
            state <= nextState(state, tms);
        end
    end

endmodule

// ==== hw/sramBridge.sv ====
/*
 * SRAM bridge.
 * Turns port requests into one-cycle SRAM strobes, captures read data.
 */
`timescale 1ns/10ps
`include "uProc_defs.svh"

module sramBridge (
    input  logic                      clk,
    input  logic                      rstN,
    input  uProcPkg::sramReq_s        sramReq,
    output logic [`UPROC_SRAM_DW-1:0] readData,
    output logic [`UPROC_SRAM_AW-1:0] sramAddr,
    output logic [`UPROC_SRAM_DW-1:0] sramDataOut,
    input  logic [`UPROC_SRAM_DW-1:0] sramDataIn,
    output logic                      sramDataOe,
    output logic                      sramWr,
    output logic                      sramEn
);
    import uProcPkg::*;

    // Strobes follow the request by one clk.
    // Requests are one clk wide, so each strobe is too.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            sramEn     <= 1'b0;
            sramWr     <= 1'b0;
            sramDataOe <= 1'b0;
        end else begin
            sramEn     <= sramReq.wr | sramReq.rd;
            sramWr     <= sramReq.wr;
            sramDataOe <= sramReq.wr;
        end
    end

    // Address and write data held until the next request.
    always_ff @(posedge clk) begin
        if (sramReq.wr || sramReq.rd) begin
            sramAddr <= sramReq.addr;
        end
        if (sramReq.wr) begin
            sramDataOut <= sramReq.data;
        end
    end

    // Read data sampled at the end of the access cycle.
    always_ff @(posedge clk) begin
        if (sramEn && !sramWr) begin
            readData <= sramDataIn;
        end
    end

endmodule

// ==== hw/uProc.sv ====
/*
 * uProc debug and programming path, top level.
 * JTAG pin synchronizer, JTAG port and SRAM bridge.
 */
`timescale 1ns/10ps
`include "uProc_defs.svh"

module uProc (
    input  logic                      clk,
    input  logic                      rstN,
    // JTAG pins.
    input  logic                      tck,
    input  logic                      tdi,
    input  logic                      tms,
    output logic                      tdo,
    // Core status.
    input  logic                      isBooted,
    input  logic                      isPaused,
    // SRAM bus with the data pin split into in, out and enable.
    output logic [`UPROC_SRAM_AW-1:0] sramAddr,
    output logic [`UPROC_SRAM_DW-1:0] sramDataOut,
    input  logic [`UPROC_SRAM_DW-1:0] sramDataIn,
    output logic                      sramDataOe,
    output logic                      sramWr,
    output logic                      sramEn,
    // Control levels to the core.
    output logic                      enScanRelay,
    output logic                      enSPIRelay,
    output logic                      enPaused
);
    import uProcPkg::*;

    // Synchronized pins with TCK on top and TMS at the bottom.
    logic [2:0]                syncPins;
    sramReq_s                  sramReq;
    logic [`UPROC_SRAM_DW-1:0] readData;

    jtagSync sync (
        .clk   (clk),
        .rstN  (rstN),
        .async ({tck, tdi, tms}),
        .sync  (syncPins)
    );

    jtagPort port (
        .clk         (clk),
        .rstN        (rstN),
        .tck         (syncPins[2]),
        .tdi         (syncPins[1]),
        .tms         (syncPins[0]),
        .tdo         (tdo),
        .isBooted    (isBooted),
        .isPaused    (isPaused),
        .readData    (readData),
        .sramReq     (sramReq),
        .enScanRelay (enScanRelay),
        .enSPIRelay  (enSPIRelay),
        .enPaused    (enPaused)
    );

    sramBridge bridge (
        .clk         (clk),
        .rstN        (rstN),
        .sramReq     (sramReq),
        .readData    (readData),
        .sramAddr    (sramAddr),
        .sramDataOut (sramDataOut),
        .sramDataIn  (sramDataIn),
        .sramDataOe  (sramDataOe),
        .sramWr      (sramWr),
        .sramEn      (sramEn)
    );

endmodule

// ==== hw/uProcPkg.sv ====
/*
 * uProc debug path types.
 * TAP states, instruction codes and data register views.
 */
`include "uProc_defs.svh"

package uProcPkg;

    // IEEE 1149.1 TAP states in the conventional encoding.
    typedef enum logic [3:0] {
        tapExit2Dr   = 4'h0, tapExit1Dr   = 4'h1, tapShiftDr   = 4'h2,
        tapPauseDr   = 4'h3, tapSelectIr  = 4'h4, tapUpdateDr  = 4'h5,
        tapCaptureDr = 4'h6, tapSelectDr  = 4'h7, tapExit2Ir   = 4'h8,
        tapExit1Ir   = 4'h9, tapShiftIr   = 4'hA, tapPauseIr   = 4'hB,
        tapIdle      = 4'hC, tapUpdateIr  = 4'hD, tapCaptureIr = 4'hE,
        tapReset     = 4'hF
    } tapState_e;

    // Supported instructions.
    // Unknown codes decode to bypass.
    typedef enum logic [`UPROC_IR_WIDTH-1:0] {
        irIdcode    = 4'h1,
        irSramWrite = 4'h2,
        irSramRead  = 4'h3,
        irControl   = 4'h4,
        irBypass    = 4'hF
    } jtagIr_e;

    // SRAM scan word with the address in the upper half.
    typedef struct packed {
        logic [`UPROC_SRAM_AW-1:0] addr;
        logic [`UPROC_SRAM_DW-1:0] data;
    } memView_s;

    // Control scan word with status above the control bits.
    typedef struct packed {
        logic [26:0] reserved;
        logic        isBooted;
        logic        isPaused;
        logic        enPaused;
        logic        enSPIRelay;
        logic        enScanRelay;
    } ctrlView_s;

    // One data register decoded per instruction.
    typedef union packed {
        logic [`UPROC_DR_WIDTH-1:0] raw;
        memView_s                   mem;
        ctrlView_s                  ctrl;
    } jtagDr_u;

    // Single-cycle request from the port to the bridge.
    typedef struct packed {
        logic                      wr;
        logic                      rd;
        logic [`UPROC_SRAM_AW-1:0] addr;
        logic [`UPROC_SRAM_DW-1:0] data;
    } sramReq_s;

endpackage

// ==== hw/uProc_defs.svh ====
/*
 * uProc debug path parameters.
 * Widths, device identifier and synchronizer depth.
 */
`ifndef UPROC_DEFS_SVH
`define UPROC_DEFS_SVH

// JTAG register widths.
`define UPROC_IR_WIDTH 4
`define UPROC_DR_WIDTH 32

// SRAM bus widths.
`define UPROC_SRAM_AW 16
`define UPROC_SRAM_DW 16

// Flip-flops per synchronized pin.
`define UPROC_SYNC_STAGES 2

// Device identifier with the LSB set as JTAG requires.
`define UPROC_IDCODE 32'h1057_A0C3

`endif

// ==== run.sh ====
#!/bin/sh
# Build and run the uProc testbench with Verilator.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module uProcTb
./obj_dir/VuProcTb | tee /dev/stderr | grep -x "Simulation passed" > /dev/null

// ==== tb.f ====
+incdir+hw
hw/uProcPkg.sv
hw/jtagSync.sv
hw/jtagTap.sv
hw/jtagPort.sv
hw/sramBridge.sv
hw/uProc.sv
dv/uProcChecker.sv
dv/uProcTb.sv
